//--- list.f
+incdir+include
design/fsmc_pkg.sv
design/bank_cfg_select.sv
design/phase_timer.sv
design/nor_seq_fsm.sv
design/bus_drive.sv
design/read_capture.sv
design/fsmc_nor_ctrl.sv
sim/nor_mem_model.sv
sim/tb_fsmc_nor_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f list.f --top-module tb_fsmc_nor_ctrl -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

//--- sim/tb_fsmc_nor_ctrl.sv
// ----------------------------------------
// random accesses against a shadow memory
// test window is halfwords 0..31 per bank,
// the memory model decodes 64 halfwords
// ----------------------------------------
`timescale 1ns/1ps
`include "fsmc_defines.svh"

module tb_fsmc_nor_ctrl
  import fsmc_pkg::*;
();

  localparam int CLK_NS   = 10;
  localparam int PHASES   = 6;
  localparam int REQS     = 40;
  // word read at addset 3, datast 5, plus handshake
  localparam int WORST_CY = 2 * (3 + 1 + 5 + 2) + 1 + 3;
  localparam int WATCH_NS = PHASES * REQS * WORST_CY * CLK_NS + 2000;

  logic       hclk;
  logic       hresetn;
  logic       req_valid;
  fsmc_req_t  req;
  logic       req_ready;
  logic       rsp_valid;
  fsmc_rsp_t  rsp;
  bank_regs_t regs;
  fsmc_pins_t pins;
  bus_data_t  fsmc_di;

  bus_data_t  shadow [`FSMC_NUM_BANKS][64];

  // expectations of the access in flight
  logic       exp_bad;
  bank_idx_t  exp_bank;
  bus_addr_t  exp_addr;
  int         exp_d;
  int         nwe_run;
  int         wr_halves;
  logic [`FSMC_NUM_BANKS-1:0] ne_exp;

  fsmc_nor_ctrl u_fsmc_nor_ctrl (
    .hclk      (hclk),
    .hresetn   (hresetn),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .regs      (regs),
    .pins      (pins),
    .fsmc_di   (fsmc_di)
  );

  nor_mem_model u_mem (
    .pins    (pins),
    .fsmc_di (fsmc_di)
  );

  initial hclk = 1'b0;
  always #(CLK_NS / 2) hclk = ~hclk;

  assign ne_exp = ~(`FSMC_NUM_BANKS'(1) << exp_bank);

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got=%08h exp=%08h", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic bus_data_t fill_word(int sel, int i);
    return bus_data_t'(sel * 'h4001) ^ bus_data_t'(i * 'h0103) ^ 16'h5a5a;
  endfunction

  function automatic reg_word_t timing_word();
    reg_word_t w;
    w = $urandom;
    w[`FSMC_BTR_ADDSET_LSB +: 4] = 4'($urandom % 4);
    w[`FSMC_BTR_DATAST_LSB +: 8] = 8'($urandom % 6);
    return w;
  endfunction

  task automatic randomize_regs();
    bank_regs_t r;
    r = '0;
    for (int b = 0; b < `FSMC_NUM_BANKS; b++) begin
      r.bcr[b] = $urandom;
      r.bcr[b][`FSMC_BCR_MBKEN]  = ($urandom % 8) != 0;
      r.bcr[b][`FSMC_BCR_WREN]   = ($urandom % 4) != 0;
      r.bcr[b][`FSMC_BCR_EXTMOD] = 1'($urandom);
      r.btr[b]  = timing_word();
      r.bwtr[b] = timing_word();
    end
    regs <= r;
  endtask

  task automatic run_access(logic write, xfer_size_t size, bank_idx_t bank, int hidx,
                            logic lsb);
    fsmc_req_t   r;
    reg_word_t   bcr;
    reg_word_t   tim;
    logic        bad;
    int          d;
    int          halves;
    int          exp_lat;
    int          lat;
    logic [31:0] exp_rdata;
    r.write = write;
    r.size  = size;
    r.addr  = host_addr_t'({8'(hidx), lsb});
    r.addr[`FSMC_HOST_ADDR_W-1 -: 2] = bank;
    r.wdata = $urandom;

    @(posedge hclk);
    // reference timing from the register images
    bcr    = regs.bcr[bank];
    tim    = (write && bcr[`FSMC_BCR_EXTMOD]) ? regs.bwtr[bank] : regs.btr[bank];
    d      = (tim[`FSMC_BTR_DATAST_LSB +: 8] == 0) ? 1 : int'(tim[`FSMC_BTR_DATAST_LSB +: 8]);
    halves = (size == SIZE_WORD) ? 2 : 1;
    bad    = !bcr[`FSMC_BCR_MBKEN] || (write && !bcr[`FSMC_BCR_WREN]);
    exp_lat = bad ? 1 : halves * (int'(tim[3:0]) + 1 + d + (write ? 1 : 2)) + 1;

    req_valid <= 1'b1;
    req       <= r;
    exp_bad   = bad;
    exp_bank  = bank;
    exp_addr  = bus_addr_t'(hidx);
    exp_d     = d;
    wr_halves = 0;
    @(negedge hclk);
    while (!req_ready) begin
      @(negedge hclk);
    end
    // acceptance edge
    @(posedge hclk);
    req_valid <= 1'b0;
    lat = 0;
    do begin
      @(negedge hclk);
      lat++;
    end while (!rsp_valid);

    check("rsp_latency", 32'(lat), 32'(exp_lat));
    check("rsp.err", 32'(rsp.err), 32'(bad));
    check("write_halves", 32'(wr_halves), (write && !bad) ? 32'(halves) : 32'(0));
    if (!bad && !write) begin
      if (size == SIZE_WORD) begin
        exp_rdata = {shadow[bank][hidx + 1], shadow[bank][hidx]};
      end else begin
        exp_rdata = {16'h0000, shadow[bank][hidx]};
      end
      check("rsp.rdata", rsp.rdata, exp_rdata);
    end
    if (!bad && write) begin
      if (size == SIZE_BYTE && lsb) begin
        shadow[bank][hidx][15:8] = r.wdata[15:8];
      end else if (size == SIZE_BYTE) begin
        shadow[bank][hidx][7:0] = r.wdata[7:0];
      end else begin
        shadow[bank][hidx] = r.wdata[15:0];
        if (size == SIZE_WORD) begin
          shadow[bank][hidx + 1] = r.wdata[31:16];
        end
      end
    end
  endtask

  //----------------------------------------
  // pin monitor, sampled mid cycle
  //----------------------------------------
  always @(negedge hclk) begin
    if (hresetn) begin
      check("ne_one_hot", 32'($countones(~pins.ne) <= 1), 32'(1));
      if (pins.ne != '1) begin
        check("refused_access_ne", 32'(exp_bad), 32'(0));
        check("pins.ne", 32'(pins.ne), 32'(ne_exp));
      end else begin
        check("pins.noe", 32'(pins.noe), 32'(1));
        check("pins.nwe", 32'(pins.nwe), 32'(1));
        check("pins.data_oe", 32'(pins.data_oe), 32'(0));
      end
      // no write data on the bus while the memory drives it
      if (!pins.noe) begin
        check("pins.data_oe", 32'(pins.data_oe), 32'(0));
      end
      if (!pins.nwe) begin
        nwe_run++;
        check("pins.a", 32'(pins.a), 32'(exp_addr) + 32'(wr_halves));
        check("pins.noe", 32'(pins.noe), 32'(1));
        check("pins.data_oe", 32'(pins.data_oe), 32'(1));
      end else if (nwe_run != 0) begin
        check("nwe_low_cycles", 32'(nwe_run), 32'(exp_d));
        nwe_run = 0;
        wr_halves++;
      end
    end
  end

  initial begin
    #(WATCH_NS);
    $display("timeout: test did not finish within %0d ns", WATCH_NS);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(15871));
    hresetn   = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    regs      = '0;
    exp_bad   = 1'b0;
    exp_bank  = '0;
    exp_addr  = '0;
    exp_d     = 0;
    nwe_run   = 0;
    wr_halves = 0;
    for (int b = 0; b < `FSMC_NUM_BANKS; b++) begin
      for (int i = 0; i < 64; i++) begin
        shadow[b][i] = fill_word(b, i);
      end
    end
    repeat (3) @(posedge hclk);
    hresetn <= 1'b1;

    @(negedge hclk);
    check("req_ready", 32'(req_ready), 32'(1));
    check("rsp_valid", 32'(rsp_valid), 32'(0));
    check("pins.ne", 32'(pins.ne), 32'(4'hf));
    check("pins.noe", 32'(pins.noe), 32'(1));
    check("pins.nwe", 32'(pins.nwe), 32'(1));
    check("pins.nbl", 32'(pins.nbl), 32'(2'b11));
    check("pins.data_oe", 32'(pins.data_oe), 32'(0));
    check("pins.a", 32'(pins.a), 32'(0));

    for (int p = 0; p < PHASES; p++) begin
      @(posedge hclk);
      randomize_regs();
      for (int n = 0; n < REQS; n++) begin
        logic       wr;
        xfer_size_t sz;
        // mostly writes early in a phase, mostly reads later
        wr = (n < REQS / 2) ? (($urandom % 4) != 0) : (($urandom % 4) == 0);
        sz = xfer_size_t'(2'($urandom % 3));
        run_access(wr, sz, bank_idx_t'($urandom), int'($urandom % 31),
                   (sz == SIZE_BYTE) ? 1'($urandom) : 1'b0);
      end
    end

    repeat (2) @(posedge hclk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- sim/nor_mem_model.sv
// ----------------------------------------
// behavioral 16-bit asynchronous memory
// one array per chip select, 64 halfwords
// each, only the low address bits decode
// power-up contents follow a fixed pattern
// ----------------------------------------
`timescale 1ns/1ps
`include "fsmc_defines.svh"

module nor_mem_model
  import fsmc_pkg::*;
(
  input  fsmc_pins_t pins,
  output bus_data_t  fsmc_di
);

  localparam int DEPTH = 64;
  localparam int IDX_W = $clog2(DEPTH);

  bus_data_t        mem [`FSMC_NUM_BANKS][DEPTH];
  bank_idx_t        cs;
  logic             cs_low;
  logic [IDX_W-1:0] idx;

  // pattern over chip select and index
  function automatic bus_data_t fill_word(int sel, int i);
    return bus_data_t'(sel * 'h4001) ^ bus_data_t'(i * 'h0103) ^ 16'h5a5a;
  endfunction

  initial begin
    for (int b = 0; b < `FSMC_NUM_BANKS; b++) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[b][i] = fill_word(b, i);
      end
    end
  end

  always_comb begin
    cs_low = 1'b0;
    cs     = '0;
    for (int i = 0; i < `FSMC_NUM_BANKS; i++) begin
      if (!pins.ne[i]) begin
        cs_low = 1'b1;
        cs     = bank_idx_t'(i);
      end
    end
  end

  assign idx     = pins.a[IDX_W-1:0];
  assign fsmc_di = (cs_low && !pins.noe) ? mem[cs][idx] : '1;

  // write on the rising edge of nwe, lanes gated by nbl
  always @(posedge pins.nwe) begin
    if (cs_low) begin
      if (!pins.nbl[0]) begin
        mem[cs][idx][7:0] = pins.dout[7:0];
      end
      if (!pins.nbl[1]) begin
        mem[cs][idx][15:8] = pins.dout[15:8];
      end
    end
  end

endmodule

//--- design/fsmc_nor_ctrl.sv
// ----------------------------------------
// NOR/SRAM bank of the static memory
// controller, asynchronous mode 1 only
// valid/ready request, single-cycle response
// with no back-pressure
// ----------------------------------------
`timescale 1ns/1ps

module fsmc_nor_ctrl
  import fsmc_pkg::*;
(
  input  logic       hclk,
  input  logic       hresetn,
  input  logic       req_valid,
  input  fsmc_req_t  req,
  output logic       req_ready,
  output logic       rsp_valid,
  output fsmc_rsp_t  rsp,
  input  bank_regs_t regs,
  output fsmc_pins_t pins,
  input  bus_data_t  fsmc_di
);

  fsmc_req_t      cur_req;
  access_timing_t timing;
  seq_state_t     state;
  logic           second_half;
  logic           phase_done;
  logic           rsp_err;
  host_data_t     rdata;

  bank_cfg_select u_bank_cfg_select (
    .cur_req (cur_req),
    .regs    (regs),
    .timing  (timing)
  );

  phase_timer u_phase_timer (
    .hclk       (hclk),
    .hresetn    (hresetn),
    .state      (state),
    .timing     (timing),
    .phase_done (phase_done)
  );

  nor_seq_fsm u_nor_seq_fsm (
    .hclk        (hclk),
    .hresetn     (hresetn),
    .req_valid   (req_valid),
    .req         (req),
    .req_ready   (req_ready),
    .timing      (timing),
    .phase_done  (phase_done),
    .state       (state),
    .second_half (second_half),
    .cur_req     (cur_req),
    .rsp_valid   (rsp_valid),
    .rsp_err     (rsp_err)
  );

  bus_drive u_bus_drive (
    .state       (state),
    .second_half (second_half),
    .cur_req     (cur_req),
    .pins        (pins)
  );

  read_capture u_read_capture (
    .hclk        (hclk),
    .hresetn     (hresetn),
    .state       (state),
    .phase_done  (phase_done),
    .second_half (second_half),
    .cur_req     (cur_req),
    .fsmc_di     (fsmc_di),
    .rdata       (rdata)
  );

  assign rsp.err   = rsp_err;
  assign rsp.rdata = rdata;

endmodule

//--- design/read_capture.sv
// ----------------------------------------
// collects read halfwords into the response
// byte reads return the full halfword,
// the host picks its lane
// ----------------------------------------
`timescale 1ns/1ps

module read_capture
  import fsmc_pkg::*;
(
  input  logic       hclk,
  input  logic       hresetn,
  input  seq_state_t state,
  input  logic       phase_done,
  input  logic       second_half,
  input  fsmc_req_t  cur_req,
  input  bus_data_t  fsmc_di,
  output host_data_t rdata
);

  localparam int HW = $bits(bus_data_t);

  logic capture;

  // sample at the edge closing the read data phase
  assign capture = (state == ST_DATA_R) && phase_done;

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      rdata <= '0;
    end else if (capture) begin
      if (second_half) begin
        rdata[2*HW-1:HW] <= fsmc_di;
      end else begin
        rdata[HW-1:0] <= fsmc_di;
        if (cur_req.size != SIZE_WORD) begin
          rdata[2*HW-1:HW] <= '0;
        end
      end
    end
  end

endmodule

//--- design/bus_drive.sv
// ----------------------------------------
// memory pin decode from the sequencer state
// purely combinational, pins idle high
// outside an access
// address is the halfword offset in the bank
// ----------------------------------------
`timescale 1ns/1ps
`include "fsmc_defines.svh"

module bus_drive
  import fsmc_pkg::*;
(
  input  seq_state_t state,
  input  logic       second_half,
  input  fsmc_req_t  cur_req,
  output fsmc_pins_t pins
);

  localparam int BANK_LSB = `FSMC_HOST_ADDR_W - $bits(bank_idx_t);

  bank_idx_t bank;
  bus_addr_t half_addr;
  logic      active;
  logic      wr_data;

  assign bank   = cur_req.addr[`FSMC_HOST_ADDR_W-1 -: $bits(bank_idx_t)];
  assign active = (state != ST_IDLE) && (state != ST_RESP);

  // write data stays on the bus through the finish cycle
  assign wr_data = (state == ST_DATA_W) || (state == ST_WR_FINISH);

  // byte offset inside the bank, divided by two
  assign half_addr = bus_addr_t'(cur_req.addr[BANK_LSB-1:1]) + bus_addr_t'(second_half);

  always_comb begin
    pins.a       = '0;
    pins.dout    = '0;
    pins.data_oe = 1'b0;
    pins.ne      = '1;
    pins.noe     = 1'b1;
    pins.nwe     = 1'b1;
    pins.nbl     = 2'b11;
    if (active) begin
      pins.a        = half_addr;
      pins.ne[bank] = 1'b0;
      if (cur_req.size == SIZE_BYTE) begin
        // even byte on the low lane
        pins.nbl = cur_req.addr[0] ? 2'b01 : 2'b10;
      end else begin
        pins.nbl = 2'b00;
      end
      pins.nwe = !(state == ST_DATA_W);
      pins.noe = !((state == ST_DATA_R) || (state == ST_RD_HOLD));
      if (wr_data) begin
        pins.data_oe = 1'b1;
        pins.dout    = second_half ? cur_req.wdata[31:16] : cur_req.wdata[15:0];
      end
    end
  end

endmodule

//--- design/nor_seq_fsm.sv
// ----------------------------------------
// access sequencer, one request at a time
// word accesses run as two halfword halves
// while idle cur_req follows the host input
// so a bad bank is refused at acceptance
// ----------------------------------------
`timescale 1ns/1ps
`include "fsmc_defines.svh"

module nor_seq_fsm
  import fsmc_pkg::*;
(
  input  logic           hclk,
  input  logic           hresetn,
  input  logic           req_valid,
  input  fsmc_req_t      req,
  output logic           req_ready,
  input  access_timing_t timing,
  input  logic           phase_done,
  output seq_state_t     state,
  output logic           second_half,
  output fsmc_req_t      cur_req,
  output logic           rsp_valid,
  output logic           rsp_err
);

  localparam int HOLD_W = $clog2(`FSMC_RD_HOLD_CYCLES + 1);
  localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(`FSMC_RD_HOLD_CYCLES - 1);

  seq_state_t        state_q;
  seq_state_t        state_d;
  fsmc_req_t         req_q;
  logic              half_q;
  logic              err_q;
  logic [HOLD_W-1:0] hold_cnt;
  logic              accept;
  logic              req_bad;
  logic              last_half;

  assign accept    = req_valid && (state_q == ST_IDLE);
  assign req_bad   = !timing.enabled || (req.write && !timing.write_allowed);
  assign last_half = (req_q.size != SIZE_WORD) || half_q;

  //----------------------------------------
  // next state
  //----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req_valid) begin
          state_d = req_bad ? ST_RESP : ST_ADDSET;
        end
      end
      ST_ADDSET: begin
        if (phase_done) begin
          state_d = req_q.write ? ST_DATA_W : ST_DATA_R;
        end
      end
      ST_DATA_W: begin
        if (phase_done) begin
          state_d = ST_WR_FINISH;
        end
      end
      ST_WR_FINISH: begin
        state_d = last_half ? ST_RESP : ST_ADDSET;
      end
      ST_DATA_R: begin
        if (phase_done) begin
          state_d = ST_RD_HOLD;
        end
      end
      ST_RD_HOLD: begin
        if (hold_cnt == HOLD_LAST) begin
          state_d = last_half ? ST_RESP : ST_ADDSET;
        end
      end
      ST_RESP: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      state_q  <= ST_IDLE;
      half_q   <= 1'b0;
      err_q    <= 1'b0;
      hold_cnt <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        half_q <= 1'b0;
        err_q  <= req_bad;
      end else if (state_d == ST_ADDSET && state_q != ST_ADDSET) begin
        // re-entering address setup only happens for the upper half
        half_q <= 1'b1;
      end
      if (state_q == ST_RD_HOLD) begin
        hold_cnt <= hold_cnt + HOLD_W'(1);
      end else begin
        hold_cnt <= '0;
      end
    end
  end

  // request payload
  always_ff @(posedge hclk) begin
    if (accept) begin
      req_q <= req;
    end
  end

  assign cur_req     = (state_q == ST_IDLE) ? req : req_q;
  assign state       = state_q;
  assign second_half = half_q;
  assign req_ready   = (state_q == ST_IDLE);
  assign rsp_valid   = (state_q == ST_RESP);
  assign rsp_err     = err_q;

endmodule

//--- design/phase_timer.sv
// ----------------------------------------
// cycle counter for the timed bus phases
// ADDSET lasts addset+1 cycles, the data
// phase datast cycles with zero read as one
// ----------------------------------------
`timescale 1ns/1ps

module phase_timer
  import fsmc_pkg::*;
(
  input  logic           hclk,
  input  logic           hresetn,
  input  seq_state_t     state,
  input  access_timing_t timing,
  output logic           phase_done
);

  seq_state_t state_q;
  datast_t    cnt_q;
  datast_t    cnt_cur;
  datast_t    data_last;
  logic       in_addset;
  logic       in_data;

  assign in_addset = (state == ST_ADDSET);
  assign in_data   = (state == ST_DATA_W) || (state == ST_DATA_R);

  // count starts over on the first cycle of any new state
  assign cnt_cur = (state != state_q) ? '0 : cnt_q;

  // index of the last data cycle
  assign data_last = (timing.datast == '0) ? '0 : timing.datast - datast_t'(1);

  assign phase_done = (in_addset && (cnt_cur == datast_t'(timing.addset))) ||
                      (in_data && (cnt_cur == data_last));

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state;
      if (in_addset || in_data) begin
        cnt_q <= cnt_cur + datast_t'(1);
      end else begin
        cnt_q <= '0;
      end
    end
  end

endmodule

//--- design/bank_cfg_select.sv
// ----------------------------------------
// picks the register images of the bank
// addressed by the current request
// write timing only applies to writes with
// extended mode set, reads use BTR always
// ----------------------------------------
`timescale 1ns/1ps
`include "fsmc_defines.svh"

module bank_cfg_select
  import fsmc_pkg::*;
(
  input  fsmc_req_t      cur_req,
  input  bank_regs_t     regs,
  output access_timing_t timing
);

  bank_idx_t bank;
  reg_word_t bcr_sel;
  reg_word_t btr_sel;
  reg_word_t bwtr_sel;
  reg_word_t tim_sel;
  logic      use_wr_timing;

  // bank bits sit at the top of the host address
  assign bank = cur_req.addr[`FSMC_HOST_ADDR_W-1 -: $bits(bank_idx_t)];

  assign bcr_sel  = regs.bcr[bank];
  assign btr_sel  = regs.btr[bank];
  assign bwtr_sel = regs.bwtr[bank];

  assign use_wr_timing = cur_req.write & bcr_sel[`FSMC_BCR_EXTMOD];
  assign tim_sel       = use_wr_timing ? bwtr_sel : btr_sel;

  //----------------------------------------
  // decoded fields
  //----------------------------------------
  assign timing.enabled       = bcr_sel[`FSMC_BCR_MBKEN];
  assign timing.write_allowed = bcr_sel[`FSMC_BCR_WREN];
  assign timing.addset        = tim_sel[`FSMC_BTR_ADDSET_LSB +: `FSMC_BTR_ADDSET_W];
  assign timing.datast        = tim_sel[`FSMC_BTR_DATAST_LSB +: `FSMC_BTR_DATAST_W];

endmodule

//--- design/fsmc_pkg.sv
// ----------------------------------------
// shared types of the NOR/SRAM controller
// widths come from the defines header
// ----------------------------------------
`include "fsmc_defines.svh"

package fsmc_pkg;

  typedef logic [`FSMC_REG_W-1:0]                  reg_word_t;
  typedef logic [`FSMC_HOST_ADDR_W-1:0]            host_addr_t;
  typedef logic [`FSMC_HOST_DATA_W-1:0]            host_data_t;
  typedef logic [`FSMC_BUS_ADDR_W-1:0]             bus_addr_t;
  typedef logic [`FSMC_BUS_DATA_W-1:0]             bus_data_t;
  typedef logic [`FSMC_BTR_ADDSET_W-1:0]           addset_t;
  typedef logic [`FSMC_BTR_DATAST_W-1:0]           datast_t;
  typedef logic [$clog2(`FSMC_NUM_BANKS)-1:0]      bank_idx_t;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } xfer_size_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDSET,
    ST_DATA_W,
    ST_WR_FINISH,
    ST_DATA_R,
    ST_RD_HOLD,
    ST_RESP
  } seq_state_t;

  // host request, held by the host until accepted
  typedef struct packed {
    logic       write;
    xfer_size_t size;
    host_addr_t addr;
    host_data_t wdata;
  } fsmc_req_t;

  typedef struct packed {
    logic       err;
    host_data_t rdata;
  } fsmc_rsp_t;

  // control, read timing and write timing images per region
  typedef struct packed {
    reg_word_t [`FSMC_NUM_BANKS-1:0] bcr;
    reg_word_t [`FSMC_NUM_BANKS-1:0] btr;
    reg_word_t [`FSMC_NUM_BANKS-1:0] bwtr;
  } bank_regs_t;

  typedef struct packed {
    logic    enabled;
    logic    write_allowed;
    addset_t addset;
    datast_t datast;
  } access_timing_t;

  // memory side pins, strobes active low
  typedef struct packed {
    bus_addr_t                   a;
    bus_data_t                   dout;
    logic                        data_oe;
    logic [`FSMC_NUM_BANKS-1:0]  ne;
    logic                        noe;
    logic                        nwe;
    logic [1:0]                  nbl;
  } fsmc_pins_t;

endpackage

//--- include/fsmc_defines.svh
// ----------------------------------------
// widths and register bit positions for the
// NOR/SRAM static-memory controller
// timing fields follow the FSMC BTR/BWTR layout,
// only ADDSET and DATAST are decoded
// ----------------------------------------
`ifndef FSMC_DEFINES_SVH
`define FSMC_DEFINES_SVH

// bank regions, one chip select each
`define FSMC_NUM_BANKS       4

// host side byte address, top bits pick the bank
`define FSMC_HOST_ADDR_W     28
`define FSMC_HOST_DATA_W     32
`define FSMC_REG_W           32

// memory bus, halfword addressed
`define FSMC_BUS_ADDR_W      26
`define FSMC_BUS_DATA_W      16

// control register bits
`define FSMC_BCR_MBKEN       0
`define FSMC_BCR_WREN        12
`define FSMC_BCR_EXTMOD      14

// timing register fields
`define FSMC_BTR_ADDSET_LSB  0
`define FSMC_BTR_ADDSET_W    4
`define FSMC_BTR_DATAST_LSB  8
`define FSMC_BTR_DATAST_W    8

// fixed read hold after the data phase
`define FSMC_RD_HOLD_CYCLES  2

`endif
